/* include/gs_params.svh */
// ################################################
// Gather-scatter tile parameters
// widths, depths, credit count and host address map
// ################################################
`ifndef GS_PARAMS_SVH
`define GS_PARAMS_SVH

`define GS_DATA_W        32
`define GS_HOST_ADDR_W   8
`define GS_REMOTE_ADDR_W 16
`define GS_DMEM_WORDS    64
`define GS_TAGS          8
`define GS_MAX_CREDITS   8
`define GS_INVALID_DATA  32'hdeadbeef

// host word address map
`define GS_ADDR_RUN      2'd0
`define GS_ADDR_LENGTH   2'd1
`define GS_ADDR_STRIDE   2'd2
`define GS_ADDR_BASE     2'd3
`define GS_DMEM_SEL_BIT  6

// run data fields, wakeup address sits in the low remote-address bits
`define GS_RUN_SCATTER_BIT 31

`endif

/* src/gs_pkg.sv */
// ################################################
// Gather-scatter shared types
// data, address, index, tag and FSM state types
// ################################################
`include "gs_params.svh"

package gs_pkg;

  localparam int DMEM_IDX_W = $clog2(`GS_DMEM_WORDS);
  localparam int TAG_W      = $clog2(`GS_TAGS);

  typedef logic [`GS_DATA_W-1:0]        word_t;
  typedef logic [`GS_HOST_ADDR_W-1:0]   host_addr_t;
  typedef logic [`GS_REMOTE_ADDR_W-1:0] remote_addr_t;
  typedef logic [DMEM_IDX_W-1:0]        dmem_idx_t;
  // one extra bit so a full-DMEM length fits
  typedef logic [DMEM_IDX_W:0]          len_t;
  typedef logic [TAG_W-1:0]             tag_t;

  typedef enum logic [1:0] {
    IDLE,
    GATHER,
    SCATTER,
    WAKEUP
  } gs_state_e;

endpackage

/* src/gs_dmem_if.sv */
// ################################################
// DMEM client interface
// one request channel plus registered read data
// ################################################
`timescale 1ns/1ns

interface gs_dmem_if;
  import gs_pkg::*;

  logic      en;
  logic      we;
  dmem_idx_t idx;
  word_t     wdata;
  // valid the cycle after a read with en high
  word_t     rdata;

  modport client (output en, output we, output idx, output wdata, input rdata);
  modport mem (input en, input we, input idx, input wdata, output rdata);

endinterface

/* src/gs_dmem.sv */
// ################################################
// Local data memory
// single-port synchronous word array shared by the
// host port and the engine
// ################################################
`timescale 1ns/1ns
`include "gs_params.svh"

module gs_dmem (
  input logic    clk_i,
  input logic    reset_i,
  gs_dmem_if.mem host_mem,
  gs_dmem_if.mem eng_mem
);
  import gs_pkg::*;

  word_t     mem_q [0:`GS_DMEM_WORDS-1];
  word_t     rdata_q;
  logic      sel_en;
  logic      sel_we;
  dmem_idx_t sel_idx;
  word_t     sel_wdata;

  // clients never collide, engine only runs while the host is held off
  always_comb begin
    if (eng_mem.en) begin
      sel_en    = 1'b1;
      sel_we    = eng_mem.we;
      sel_idx   = eng_mem.idx;
      sel_wdata = eng_mem.wdata;
    end else begin
      sel_en    = host_mem.en;
      sel_we    = host_mem.we;
      sel_idx   = host_mem.idx;
      sel_wdata = host_mem.wdata;
    end
  end

  always_ff @(posedge clk_i) begin
    if (sel_en) begin
      if (sel_we) begin
        mem_q[sel_idx] <= sel_wdata;
      end else begin
        rdata_q <= mem_q[sel_idx];
      end
    end
  end

  // read data is shared, each client knows when it asked
  assign host_mem.rdata = rdata_q;
  assign eng_mem.rdata  = rdata_q;

  a_single_client: assert property (@(posedge clk_i) disable iff (reset_i)
    !(host_mem.en && eng_mem.en));

endmodule

/* src/gs_host_port.sv */
// ################################################
// Host access port
// decodes host addresses, holds the control
// registers, launches runs and returns responses
// ################################################
`timescale 1ns/1ns
`include "gs_params.svh"

module gs_host_port (
  input  logic                 clk_i,
  input  logic                 reset_i,
  input  logic                 host_v_i,
  input  logic                 host_we_i,
  input  gs_pkg::host_addr_t   host_addr_i,
  input  gs_pkg::word_t        host_wdata_i,
  output logic                 host_ready_o,
  output logic                 host_rsp_v_o,
  output gs_pkg::word_t        host_rsp_data_o,
  input  logic                 busy_i,
  output logic                 run_o,
  output logic                 scatter_o,
  output gs_pkg::len_t         len_o,
  output gs_pkg::remote_addr_t stride_o,
  output gs_pkg::remote_addr_t base_o,
  output gs_pkg::remote_addr_t wake_addr_o,
  gs_dmem_if.client            mem
);
  import gs_pkg::*;

  logic         accept;
  logic         is_csr;
  logic         is_dmem;
  logic         csr_wr;
  len_t         len_q;
  remote_addr_t stride_q;
  remote_addr_t base_q;
  remote_addr_t wake_q;
  logic         rsp_v_q;
  logic         rsp_dmem_q;
  logic         rsp_inv_q;

  // only accept while the engine is idle
  assign host_ready_o = ~busy_i;
  assign accept       = host_v_i & host_ready_o;

  assign is_csr  = (host_addr_i[`GS_HOST_ADDR_W-1:2] == '0);
  assign is_dmem = host_addr_i[`GS_DMEM_SEL_BIT] &
                   (host_addr_i[`GS_HOST_ADDR_W-1:`GS_DMEM_SEL_BIT+1] == '0);
  assign csr_wr  = accept & host_we_i & is_csr;

  // run pulse, the engine latches its state on it
  assign run_o     = csr_wr & (host_addr_i[1:0] == `GS_ADDR_RUN);
  assign scatter_o = host_wdata_i[`GS_RUN_SCATTER_BIT];

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      len_q    <= '0;
      stride_q <= '0;
      base_q   <= '0;
      wake_q   <= '0;
    end else if (csr_wr) begin
      case (host_addr_i[1:0])
        `GS_ADDR_RUN:    wake_q   <= host_wdata_i[`GS_REMOTE_ADDR_W-1:0];
        `GS_ADDR_LENGTH: len_q    <= len_t'(host_wdata_i);
        `GS_ADDR_STRIDE: stride_q <= remote_addr_t'(host_wdata_i);
        default:         base_q   <= remote_addr_t'(host_wdata_i);
      endcase
    end
  end

  assign len_o       = len_q;
  assign stride_o    = stride_q;
  assign base_o      = base_q;
  assign wake_addr_o = wake_q;

  // DMEM window
  assign mem.en    = accept & is_dmem;
  assign mem.we    = host_we_i;
  assign mem.idx   = dmem_idx_t'(host_addr_i);
  assign mem.wdata = host_wdata_i;

  // remember what kind of answer goes out next cycle
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      rsp_v_q    <= 1'b0;
      rsp_dmem_q <= 1'b0;
      rsp_inv_q  <= 1'b0;
    end else begin
      rsp_v_q    <= accept;
      rsp_dmem_q <= accept & ~host_we_i & is_dmem;
      rsp_inv_q  <= accept & ~host_we_i & ~is_dmem;
    end
  end

  assign host_rsp_v_o = rsp_v_q;

  always_comb begin
    if (rsp_dmem_q) begin
      host_rsp_data_o = mem.rdata;
    end else if (rsp_inv_q) begin
      host_rsp_data_o = `GS_INVALID_DATA;
    end else begin
      host_rsp_data_o = '0;
    end
  end

endmodule

/* src/gs_tag_pool.sv */
// ################################################
// Load tag pool
// hands out free tags and remembers the DMEM index
// each outstanding load belongs to
// ################################################
`timescale 1ns/1ns
`include "gs_params.svh"

module gs_tag_pool (
  input  logic              clk_i,
  input  logic              reset_i,
  input  logic              alloc_i,
  input  gs_pkg::dmem_idx_t alloc_idx_i,
  output logic              free_v_o,
  output gs_pkg::tag_t      free_tag_o,
  input  logic              release_i,
  input  gs_pkg::tag_t      release_tag_i,
  output gs_pkg::dmem_idx_t release_idx_o,
  output logic              all_free_o
);
  import gs_pkg::*;

  logic [`GS_TAGS-1:0] free_q;
  dmem_idx_t           idx_table_q [0:`GS_TAGS-1];

  // lowest free tag wins
  always_comb begin
    free_tag_o = '0;
    for (int i = `GS_TAGS - 1; i >= 0; i--) begin
      if (free_q[i]) begin
        free_tag_o = tag_t'(i);
      end
    end
  end

  assign free_v_o   = |free_q;
  assign all_free_o = &free_q;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      free_q <= '1;
    end else begin
      if (alloc_i) begin
        free_q[free_tag_o] <= 1'b0;
      end
      if (release_i) begin
        free_q[release_tag_i] <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (alloc_i) begin
      idx_table_q[free_tag_o] <= alloc_idx_i;
    end
  end

  assign release_idx_o = idx_table_q[release_tag_i];

  // a response must carry a tag that some earlier load took
  a_release_held: assert property (@(posedge clk_i) disable iff (reset_i)
    release_i |-> !free_q[release_tag_i]);

endmodule

/* src/gs_engine.sv */
// ################################################
// Gather-scatter engine
// operation FSM, element counter, remote address
// generation and outgoing credit tracking
// ################################################
`timescale 1ns/1ns
`include "gs_params.svh"

module gs_engine (
  input  logic                 clk_i,
  input  logic                 reset_i,
  input  logic                 run_i,
  input  logic                 scatter_i,
  input  gs_pkg::len_t         len_i,
  input  gs_pkg::remote_addr_t stride_i,
  input  gs_pkg::remote_addr_t base_i,
  input  gs_pkg::remote_addr_t wake_addr_i,
  output logic                 busy_o,
  output logic                 req_v_o,
  output logic                 req_we_o,
  output gs_pkg::remote_addr_t req_addr_o,
  output gs_pkg::word_t        req_data_o,
  output gs_pkg::tag_t         req_tag_o,
  input  logic                 credit_i,
  input  logic                 resp_v_i,
  input  gs_pkg::tag_t         resp_tag_i,
  input  gs_pkg::word_t        resp_data_i,
  output logic                 alloc_o,
  output gs_pkg::dmem_idx_t    alloc_idx_o,
  input  logic                 free_v_i,
  input  gs_pkg::tag_t         free_tag_i,
  output logic                 release_o,
  output gs_pkg::tag_t         release_tag_o,
  input  gs_pkg::dmem_idx_t    release_idx_i,
  input  logic                 all_free_i,
  gs_dmem_if.client            mem
);
  import gs_pkg::*;

  localparam int CRED_W = $clog2(`GS_MAX_CREDITS + 1);

  gs_state_e    state_q;
  len_t         cnt_q;
  logic [CRED_W-1:0] credits_q;
  logic         st_pending_q;
  remote_addr_t st_addr_q;
  remote_addr_t addr_cur;
  logic         have_credit;
  logic         last_elem;
  logic         issue_ld;
  logic         issue_rd;
  logic         issue_wake;
  logic         spend;

  assign busy_o      = (state_q != IDLE);
  assign have_credit = (credits_q != '0);
  assign last_elem   = (cnt_q == len_t'(len_i - 1'b1));
  assign addr_cur    = base_i + remote_addr_t'(cnt_q) * stride_i;

  assign issue_ld   = (state_q == GATHER) & have_credit & free_v_i;
  // a scatter read reserves the credit its store will use next cycle
  assign issue_rd   = (state_q == SCATTER) & have_credit;
  assign issue_wake = (state_q == WAKEUP) & ~st_pending_q & all_free_i &
                      (credits_q == CRED_W'(`GS_MAX_CREDITS));
  assign spend      = issue_ld | issue_rd | issue_wake;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q <= IDLE;
      cnt_q   <= '0;
    end else begin
      case (state_q)
        IDLE: begin
          if (run_i) begin
            cnt_q <= '0;
            if (len_i == '0) begin
              state_q <= WAKEUP;
            end else begin
              state_q <= scatter_i ? SCATTER : GATHER;
            end
          end
        end
        GATHER, SCATTER: begin
          if (issue_ld | issue_rd) begin
            cnt_q <= cnt_q + 1'b1;
            if (last_elem) begin
              state_q <= WAKEUP;
            end
          end
        end
        default: begin
          if (issue_wake) begin
            state_q <= IDLE;
          end
        end
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      credits_q <= CRED_W'(`GS_MAX_CREDITS);
    end else begin
      credits_q <= credits_q - CRED_W'(spend) + CRED_W'(credit_i);
    end
  end

  // store stage of the scatter pipeline
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      st_pending_q <= 1'b0;
    end else begin
      st_pending_q <= issue_rd;
    end
  end

  always_ff @(posedge clk_i) begin
    if (issue_rd) begin
      st_addr_q <= addr_cur;
    end
  end

  // remote request mux, at most one source per cycle
  assign req_v_o   = issue_ld | st_pending_q | issue_wake;
  assign req_we_o  = st_pending_q | issue_wake;
  assign req_tag_o = issue_ld ? free_tag_i : '0;

  always_comb begin
    if (issue_ld) begin
      req_addr_o = addr_cur;
      req_data_o = '0;
    end else if (st_pending_q) begin
      req_addr_o = st_addr_q;
      req_data_o = mem.rdata;
    end else begin
      req_addr_o = wake_addr_i;
      req_data_o = word_t'(issue_wake);
    end
  end

  assign alloc_o       = issue_ld;
  assign alloc_idx_o   = dmem_idx_t'(cnt_q);
  assign release_o     = resp_v_i;
  assign release_tag_o = resp_tag_i;

  // gather responses land straight in the DMEM
  assign mem.en    = resp_v_i | issue_rd;
  assign mem.we    = resp_v_i;
  assign mem.idx   = resp_v_i ? release_idx_i : dmem_idx_t'(cnt_q);
  assign mem.wdata = resp_data_i;

  a_credit_bound: assert property (@(posedge clk_i) disable iff (reset_i)
    credits_q <= CRED_W'(`GS_MAX_CREDITS));

endmodule

/* src/gs_top.sv */
// ################################################
// Gather-scatter tile top level
// host port, engine, tag pool and DMEM
// ################################################
`timescale 1ns/1ns

module gs_top (
  input  logic                 clk_i,
  input  logic                 reset_i,
  input  logic                 host_v_i,
  input  logic                 host_we_i,
  input  gs_pkg::host_addr_t   host_addr_i,
  input  gs_pkg::word_t        host_wdata_i,
  output logic                 host_ready_o,
  output logic                 host_rsp_v_o,
  output gs_pkg::word_t        host_rsp_data_o,
  output logic                 req_v_o,
  output logic                 req_we_o,
  output gs_pkg::remote_addr_t req_addr_o,
  output gs_pkg::word_t        req_data_o,
  output gs_pkg::tag_t         req_tag_o,
  input  logic                 credit_i,
  input  logic                 resp_v_i,
  input  gs_pkg::tag_t         resp_tag_i,
  input  gs_pkg::word_t        resp_data_i
);
  import gs_pkg::*;

  logic         busy;
  logic         run;
  logic         scatter;
  len_t         len;
  remote_addr_t stride;
  remote_addr_t base;
  remote_addr_t wake_addr;
  logic         alloc;
  dmem_idx_t    alloc_idx;
  logic         free_v;
  tag_t         free_tag;
  logic         release_v;
  tag_t         release_tag;
  dmem_idx_t    release_idx;
  logic         all_free;

  gs_dmem_if host_mem_if ();
  gs_dmem_if eng_mem_if ();

  gs_host_port u_host_port (
    .clk_i, .reset_i, .host_v_i, .host_we_i, .host_addr_i, .host_wdata_i,
    .host_ready_o, .host_rsp_v_o, .host_rsp_data_o,
    .busy_i(busy), .run_o(run), .scatter_o(scatter), .len_o(len),
    .stride_o(stride), .base_o(base), .wake_addr_o(wake_addr),
    .mem(host_mem_if.client)
  );

  gs_engine u_engine (
    .clk_i, .reset_i, .run_i(run), .scatter_i(scatter), .len_i(len),
    .stride_i(stride), .base_i(base), .wake_addr_i(wake_addr), .busy_o(busy),
    .req_v_o, .req_we_o, .req_addr_o, .req_data_o, .req_tag_o,
    .credit_i, .resp_v_i, .resp_tag_i, .resp_data_i,
    .alloc_o(alloc), .alloc_idx_o(alloc_idx), .free_v_i(free_v), .free_tag_i(free_tag),
    .release_o(release_v), .release_tag_o(release_tag), .release_idx_i(release_idx),
    .all_free_i(all_free), .mem(eng_mem_if.client)
  );

  gs_tag_pool u_tag_pool (
    .clk_i, .reset_i, .alloc_i(alloc), .alloc_idx_i(alloc_idx),
    .free_v_o(free_v), .free_tag_o(free_tag), .release_i(release_v),
    .release_tag_i(release_tag), .release_idx_o(release_idx), .all_free_o(all_free)
  );

  gs_dmem u_dmem (
    .clk_i, .reset_i, .host_mem(host_mem_if.mem), .eng_mem(eng_mem_if.mem)
  );

endmodule

/* verif/gs_tb.sv */
// ################################################
// Gather-scatter tile testbench
// remote-memory model, case runner and checks
// ################################################
`timescale 1ns/1ns
`include "gs_params.svh"

module gs_tb;

  logic              clk_i;
  logic              reset_i;
  logic              host_v_i;
  logic              host_we_i;
  gs_pkg::host_addr_t host_addr_i;
  gs_pkg::word_t     host_wdata_i;
  logic              host_ready_o;
  logic              host_rsp_v_o;
  gs_pkg::word_t     host_rsp_data_o;
  logic              req_v_o;
  logic              req_we_o;
  gs_pkg::remote_addr_t req_addr_o;
  gs_pkg::word_t     req_data_o;
  gs_pkg::tag_t      req_tag_o;
  logic              credit_i;
  logic              resp_v_i;
  gs_pkg::tag_t      resp_tag_i;
  gs_pkg::word_t     resp_data_i;

  integer      seed = 28;
  integer      errors = 0;
  integer      tests_ok = 0;
  integer      tests_bad = 0;
  integer      cycles = 0;
  integer      limit = 1000;
  logic [31:0] remote [0:65535];
  logic [31:0] snap [0:65535];
  logic [15:0] ld_addr_q [$];
  logic [2:0]  ld_tag_q [$];
  integer      st_credits = 0;
  integer      hold_cnt = 0;
  integer      inflight = 0;
  integer      wake_count = 0;
  integer      req_count = 0;
  logic [15:0] cur_wake = 16'hffff;
  logic        expect_busy = 1'b0;
  logic        ready_next = 1'b0;
  integer      n_cases = 0;
  logic [31:0] c_op [0:31];
  logic [31:0] c_base [0:31];
  logic [31:0] c_stride [0:31];
  logic [31:0] c_len [0:31];
  logic [31:0] c_wake [0:31];
  logic [31:0] pattern [0:63];

  gs_top u_gs_top (.*);

  initial begin
    clk_i = 1'b0;
    forever #20 clk_i = ~clk_i;
  end

  task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (exp !== act) begin
      $display("FAIL %0t %s expected %h got %h", $time, name, exp, act);
      errors = errors + 1;
    end
  endtask

  // one host request and its single-cycle response
  task automatic host_access(input logic we, input logic [7:0] addr, input logic [31:0] wdata,
                             input logic arm, output logic [31:0] rdata);
    @(posedge clk_i);
    host_v_i     <= 1'b1;
    host_we_i    <= we;
    host_addr_i  <= addr;
    host_wdata_i <= wdata;
    @(negedge clk_i);
    check_val("host_ready_o", 1, host_ready_o);
    check_val("host_rsp_v_o", 0, host_rsp_v_o);
    @(posedge clk_i);
    host_v_i <= 1'b0;
    if (arm) begin
      expect_busy = 1'b1;
    end
    @(negedge clk_i);
    check_val("host_rsp_v_o", 1, host_rsp_v_o);
    rdata = host_rsp_data_o;
  endtask

  // remote side monitor and in-flight accounting
  always @(negedge clk_i) begin
    integer dup;
    if (!reset_i) begin
      if (expect_busy) begin
        check_val("host_ready_o", 0, host_ready_o);
      end else if (ready_next) begin
        check_val("host_ready_o", 1, host_ready_o);
        ready_next = 1'b0;
      end
      inflight = inflight - credit_i;
      if (req_v_o) begin
        req_count = req_count + 1;
        if (req_we_o && req_addr_o == cur_wake) begin
          check_val("wakeup_data", 1, req_data_o);
          check_val("inflight_at_wakeup", 0, inflight);
          wake_count = wake_count + 1;
          st_credits = st_credits + 1;
          expect_busy = 1'b0;
          ready_next = 1'b1;
        end else if (req_we_o) begin
          remote[req_addr_o] = req_data_o;
          st_credits = st_credits + 1;
        end else begin
          // a tag stays with its load until the response returns
          dup = 0;
          for (int j = 0; j < ld_tag_q.size(); j++) begin
            if (ld_tag_q[j] == req_tag_o) begin
              dup = dup + 1;
            end
          end
          check_val("req_tag_o_in_use", 0, dup);
          ld_addr_q.push_back(req_addr_o);
          ld_tag_q.push_back(req_tag_o);
        end
        inflight = inflight + 1;
      end
      if (inflight > `GS_MAX_CREDITS) begin
        check_val("inflight", `GS_MAX_CREDITS, inflight);
      end
    end
  end

  // remote memory answers in random order with long credit holds
  always @(posedge clk_i) begin
    integer idx;
    resp_v_i <= 1'b0;
    credit_i <= 1'b0;
    if (hold_cnt > 0) begin
      hold_cnt = hold_cnt - 1;
    end else if (($random(seed) & 63) == 0) begin
      hold_cnt = 30;
    end else if (ld_addr_q.size() > 0 && ($random(seed) & 3) == 0) begin
      idx = $unsigned($random(seed)) % ld_addr_q.size();
      resp_v_i    <= 1'b1;
      resp_tag_i  <= ld_tag_q[idx];
      resp_data_i <= remote[ld_addr_q[idx]];
      credit_i    <= 1'b1;
      ld_addr_q.delete(idx);
      ld_tag_q.delete(idx);
    end else if (st_credits > 0 && ($random(seed) & 3) == 0) begin
      credit_i <= 1'b1;
      st_credits = st_credits - 1;
    end
  end

  always @(posedge clk_i) begin
    cycles = cycles + 1;
    if (cycles > limit) begin
      $display("operation hung, no wakeup before the cycle limit");
      $display("test failed");
      $finish;
    end
  end

  task automatic control_test();
    logic [31:0] r;
    integer e0;
    e0 = errors;
    host_access(1, 8'h01, 32'h5, 0, r);
    check_val("rsp_write", 0, r);
    host_access(1, 8'h02, 32'h1, 0, r);
    check_val("rsp_write", 0, r);
    host_access(1, 8'h45, 32'hcafe0123, 0, r);
    check_val("rsp_write", 0, r);
    host_access(0, 8'h45, 0, 0, r);
    check_val("dmem_read", 32'hcafe0123, r);
    for (int a = 0; a < 4; a++) begin
      host_access(0, a[7:0], 0, 0, r);
      check_val("csr_read", 32'hdeadbeef, r);
    end
    host_access(0, 8'h80, 0, 0, r);
    check_val("unmapped_read", 32'hdeadbeef, r);
    report_test("host access", e0);
  endtask

  task automatic run_case(input integer i);
    logic [31:0] r;
    logic [15:0] a;
    integer e0;
    integer wbase;
    integer rbase;
    e0 = errors;
    if (c_op[i][0]) begin
      for (int k = 0; k < c_len[i]; k++) begin
        pattern[k] = $random(seed);
        host_access(1, 8'h40 + k[7:0], pattern[k], 0, r);
      end
    end
    for (int k = 0; k < 65536; k++) begin
      snap[k] = remote[k];
    end
    host_access(1, 8'h01, c_len[i], 0, r);
    host_access(1, 8'h02, c_stride[i], 0, r);
    host_access(1, 8'h03, c_base[i], 0, r);
    cur_wake = c_wake[i][15:0];
    wbase = wake_count;
    rbase = req_count;
    host_access(1, 8'h00, {c_op[i][0], 15'd0, c_wake[i][15:0]}, 1, r);
    while (wake_count == wbase) begin
      @(posedge clk_i);
    end
    repeat (3) @(posedge clk_i);
    check_val("wakeup_count", wbase + 1, wake_count);
    check_val("request_count", c_len[i] + 1, req_count - rbase);
    for (int k = 0; k < c_len[i]; k++) begin
      a = c_base[i][15:0] + k[15:0] * c_stride[i][15:0];
      if (c_op[i][0]) begin
        snap[a] = pattern[k];
      end else begin
        host_access(0, 8'h40 + k[7:0], 0, 0, r);
        check_val("dmem_gathered", snap[a], r);
      end
    end
    for (int k = 0; k < 65536; k++) begin
      if (remote[k] !== snap[k]) begin
        check_val("remote_mem", snap[k], remote[k]);
      end
    end
    report_test($sformatf("case %0d %s len %0d", i, c_op[i][0] ? "scatter" : "gather",
                          c_len[i]), e0);
  endtask

  task automatic report_test(input string name, input integer e0);
    if (errors == e0) begin
      tests_ok = tests_ok + 1;
      $display("%s: ok", name);
    end else begin
      tests_bad = tests_bad + 1;
      $display("%s: %0d errors", name, errors - e0);
    end
  endtask

  initial begin
    integer fd;
    integer total;
    string  line;
    reset_i      = 1'b1;
    host_v_i     = 1'b0;
    host_we_i    = 1'b0;
    host_addr_i  = '0;
    host_wdata_i = '0;
    credit_i     = 1'b0;
    resp_v_i     = 1'b0;
    resp_tag_i   = '0;
    resp_data_i  = '0;
    for (int a = 0; a < 65536; a++) begin
      remote[a] = a * 3 + 32'h100;
    end
    fd = $fopen("verif/gs_cases.txt", "r");
    if (fd == 0) begin
      $display("cannot open the case file");
      $display("test failed");
      $finish;
    end else begin
      total = 0;
      while (!$feof(fd) && n_cases < 32) begin
        line = "";
        void'($fgets(line, fd));
        if (line.len() > 0 && line.getc(0) != "#" &&
            $sscanf(line, "%h %h %h %h %h", c_op[n_cases], c_base[n_cases],
                    c_stride[n_cases], c_len[n_cases], c_wake[n_cases]) == 5) begin
          total = total + c_len[n_cases];
          n_cases = n_cases + 1;
        end
      end
      $fclose(fd);
      limit = 200 * total + 1000;
      repeat (4) @(posedge clk_i);
      reset_i <= 1'b0;
      control_test();
      for (int i = 0; i < n_cases; i++) begin
        run_case(i);
      end
      $display("tests: %0d ok, %0d failing", tests_ok, tests_bad);
      if (errors == 0 && tests_bad == 0) begin
        $display("test passed");
      end else begin
        $display("test failed");
      end
      $finish;
    end
  end

endmodule

/* verif/gs_cases.txt */
# columns, all hex: op (0 gather, 1 scatter), base, stride, length, wakeup address
# wakeup addresses stay clear of every touched remote word
0 0010 1 8  f000
0 0200 3 14 f001
1 0400 2 10 f002
1 0800 5 40 f003
0 0800 5 40 f004
0 1000 0 4  f005
1 2000 1 0  f006
0 3000 7 0  f007
1 4000 0 3  f008

/* all.f */
+incdir+include
src/gs_pkg.sv
src/gs_dmem_if.sv
src/gs_dmem.sv
src/gs_host_port.sv
src/gs_tag_pool.sv
src/gs_engine.sv
src/gs_top.sv
verif/gs_tb.sv

/* Makefile */
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert -Wall
TOP       ?= gs_tb
FILELIST  ?= all.f

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only --timing --assert -Wall -f $(FILELIST) --top-module $(TOP)

obj_dir/V$(TOP): $(FILELIST)
	$(VERILATOR) $(FLAGS) -f $(FILELIST) --top-module $(TOP)

sim: obj_dir/V$(TOP)
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "test passed"

clean:
	rm -rf obj_dir
